/* project.f */
io_map_pkg.sv
pgm_pkg.sv
boot_ctrl_regs.sv
pgm_write_queue.sv
pgm_flash.sv
pgm_loader_top.sv
tb_pgm_loader.sv

/* tb_pgm_loader.sv */
// ======================================
// Directed testbench for the program loader.
// Drives the boot register window on the IO bus
// and checks readback, io_rst and fetched words.
// ======================================

module tb_pgm_loader;
	timeunit 1ns;
	timeprecision 100ps;

	localparam int PGM_ADDR_WIDTH = 10;
	localparam int QUEUE_DEPTH = 4;
	// Longest sequence is about 250 cycles, so this leaves wide margin
	localparam int max_cycles = 2000;
	localparam logic [7:0] pgm_en_val = 8'h01 << io_map_pkg::stat_pgm_wr_en_bit;
	localparam logic [7:0] io_rst_val = 8'h01 << io_map_pkg::stat_io_rst_bit;
	localparam logic [7:0] overrun_val = 8'h01 << io_map_pkg::stat_overrun_bit;

	logic                      core_clk;
	logic                      core_rst;
	io_map_pkg::io_bus_t       io_bus;
	logic [7:0]                io_rdata;
	logic                      io_rst;
	logic [PGM_ADDR_WIDTH-1:0] fetch_addr;
	pgm_pkg::pgm_word_t        fetch_data;
	logic                      pgm_idle;
	int                        cycle_count;
	logic [31:0]               lcg_state;
	pgm_pkg::pgm_word_t        exp_words [8];

	pgm_loader_top #(
		.PGM_ADDR_WIDTH (PGM_ADDR_WIDTH),
		.QUEUE_DEPTH    (QUEUE_DEPTH)
	) uut (
		.core_clk   (core_clk),
		.core_rst   (core_rst),
		.io_bus     (io_bus),
		.io_rdata   (io_rdata),
		.io_rst     (io_rst),
		.fetch_addr (fetch_addr),
		.fetch_data (fetch_data),
		.pgm_idle   (pgm_idle)
	);

	always #2 core_clk = ~core_clk;

	always @(posedge core_clk)
	begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= max_cycles)
		begin
			$display("Timeout: the run went past %0d cycles without finishing", max_cycles);
			$display("Test failed");
			$fatal(1, "Run stopped by the cycle limit");
		end
	end

	function automatic logic [31:0] lcg_next(input logic [31:0] s);
		return s * 32'd1103515245 + 32'd12345;
	endfunction

	// Window base with the register offset in the low bits
	function automatic logic [7:0] reg_addr(input logic [2:0] off);
		return io_map_pkg::boot_reg_base | {5'b00000, off};
	endfunction

	task automatic stop_on_error(input string msg);
		$display("%s", msg);
		$display("Test failed");
		$fatal(1, "Stopped at the first error");
	endtask

	task automatic check_io_rdata(input string what, input logic [7:0] got, input logic [7:0] exp);
		if (got !== exp)
			stop_on_error($sformatf("FAILED io_rdata (%s): got %h expected %h", what, got, exp));
	endtask

	task automatic check_fetch(input string what, input pgm_pkg::pgm_word_t got,
		input pgm_pkg::pgm_word_t exp);
		if (got !== exp)
			stop_on_error($sformatf("FAILED fetch_data (%s): got %h expected %h", what, got, exp));
	endtask

	task automatic check_io_rst(input string what, input logic got, input logic exp);
		if (got !== exp)
			stop_on_error($sformatf("FAILED io_rst (%s): got %h expected %h", what, got, exp));
	endtask

	// All bus tasks start and end 1 ns after a rising edge
	task automatic io_write(input logic [7:0] addr, input logic [7:0] data);
		io_bus.addr = addr;
		io_bus.wdata = data;
		io_bus.rd = 1'b0;
		io_bus.wr = 1'b1;
		@(posedge core_clk);
		#1;
		io_bus.wr = 1'b0;
	endtask

	task automatic io_read(input logic [7:0] addr, output logic [7:0] data);
		io_bus.addr = addr;
		io_bus.rd = 1'b1;
		#1;
		data = io_rdata;  // Combinational, settled mid cycle
		@(posedge core_clk);
		#1;
		io_bus.rd = 1'b0;
	endtask

	task automatic fetch_word(input logic [15:0] addr, output pgm_pkg::pgm_word_t data);
		fetch_addr = addr[PGM_ADDR_WIDTH-1:0];
		@(posedge core_clk);
		#1;
		data = fetch_data;
	endtask

	task automatic wait_idle();
		while (!pgm_idle)
		begin
			@(posedge core_clk);
			#1;
		end
	endtask

	task automatic set_counter(input logic [15:0] addr);
		io_write(reg_addr(io_map_pkg::f_cnt_l_off), addr[7:0]);
		io_write(reg_addr(io_map_pkg::f_cnt_h_off), addr[15:8]);
	endtask

	task automatic program_word(input pgm_pkg::pgm_word_t word);
		io_write(reg_addr(io_map_pkg::f_data_l_off), word[7:0]);
		io_write(reg_addr(io_map_pkg::f_data_h_off), word[15:8]);
		wait_idle();  // Slot must be free before the next word
	endtask

	task automatic check_counter(input logic [15:0] exp);
		logic [7:0] rd;
		io_read(reg_addr(io_map_pkg::f_cnt_l_off), rd);
		check_io_rdata("f_cnt_l", rd, exp[7:0]);
		io_read(reg_addr(io_map_pkg::f_cnt_h_off), rd);
		check_io_rdata("f_cnt_h", rd, exp[15:8]);
	endtask

	task automatic reset_state_and_io_rst();
		logic [7:0] rd;
		io_read(reg_addr(io_map_pkg::boot_stat_off), rd);
		check_io_rdata("boot_stat after reset", rd, 8'h00);
		check_counter(16'h0000);
		check_io_rst("after reset", io_rst, 1'b0);
		io_write(reg_addr(io_map_pkg::boot_stat_off), io_rst_val);
		check_io_rst("bit set", io_rst, 1'b1);
		io_read(reg_addr(io_map_pkg::boot_stat_off), rd);
		check_io_rdata("boot_stat io_rst", rd, io_rst_val);
		io_write(reg_addr(io_map_pkg::boot_stat_off), 8'h00);
		check_io_rst("bit cleared", io_rst, 1'b0);
	endtask

	task automatic load_and_fetch_words();
		pgm_pkg::pgm_word_t w;
		io_write(reg_addr(io_map_pkg::boot_stat_off), pgm_en_val);
		set_counter(16'h0010);
		for (int i = 0; i < 8; i++)
		begin
			lcg_state = lcg_next(lcg_state);
			exp_words[i] = lcg_state[23:8];
			program_word(exp_words[i]);
		end
		wait_idle();
		io_write(reg_addr(io_map_pkg::boot_stat_off), 8'h00);
		for (int i = 0; i < 8; i++)
		begin
			fetch_word(16'h0010 + 16'(i), w);
			check_fetch($sformatf("word %0d", i), w, exp_words[i]);
		end
		check_counter(16'h0018);
	endtask

	task automatic fetch_while_programming();
		pgm_pkg::pgm_word_t w;
		io_write(reg_addr(io_map_pkg::boot_stat_off), pgm_en_val);
		fetch_word(16'h0010, w);
		check_fetch("programming mode", w, 16'h0000);
		io_write(reg_addr(io_map_pkg::boot_stat_off), 8'h00);
	endtask

	task automatic data_high_with_mode_off();
		pgm_pkg::pgm_word_t w;
		set_counter(16'h0017);
		io_write(reg_addr(io_map_pkg::f_data_l_off), 8'hA5);
		io_write(reg_addr(io_map_pkg::f_data_h_off), 8'h5A);
		wait_idle();
		check_counter(16'h0017);
		fetch_word(16'h0017, w);
		check_fetch("mode off write", w, exp_words[7]);
	endtask

	task automatic back_to_back_overrun();
		pgm_pkg::pgm_word_t a;
		pgm_pkg::pgm_word_t c;
		pgm_pkg::pgm_word_t w;
		logic [7:0]         rd;
		lcg_state = lcg_next(lcg_state);
		a = lcg_state[23:8];
		lcg_state = lcg_next(lcg_state);
		c = lcg_state[23:8];
		io_write(reg_addr(io_map_pkg::boot_stat_off), pgm_en_val);
		set_counter(16'h0021);
		program_word(c);  // Known word where a second write would land
		set_counter(16'h0020);
		io_write(reg_addr(io_map_pkg::f_data_l_off), a[7:0]);
		io_write(reg_addr(io_map_pkg::f_data_h_off), a[15:8]);
		io_write(reg_addr(io_map_pkg::f_data_h_off), ~a[15:8]);  // Back to back
		wait_idle();
		io_read(reg_addr(io_map_pkg::boot_stat_off), rd);
		check_io_rdata("boot_stat overrun", rd, pgm_en_val | overrun_val);
		check_counter(16'h0021);
		io_write(reg_addr(io_map_pkg::boot_stat_off), 8'h00);
		io_read(reg_addr(io_map_pkg::boot_stat_off), rd);
		check_io_rdata("boot_stat cleared", rd, 8'h00);
		fetch_word(16'h0020, w);
		check_fetch("first word", w, a);
		fetch_word(16'h0021, w);
		check_fetch("dropped word", w, c);
	endtask

	task automatic zero_readback();
		logic [7:0] rd;
		// Just below the window, low bits hit the nonzero f_cnt_l
		io_read(8'hF3, rd);
		check_io_rdata("outside window", rd, 8'h00);
		io_read(reg_addr(io_map_pkg::f_data_l_off), rd);
		check_io_rdata("f_data_l", rd, 8'h00);
		io_read(reg_addr(io_map_pkg::f_data_h_off), rd);
		check_io_rdata("f_data_h", rd, 8'h00);
		io_read(reg_addr(3'd0), rd);
		check_io_rdata("window offset 0", rd, 8'h00);
	endtask

	initial
	begin
		core_clk = 1'b0;
		core_rst = 1'b1;
		io_bus = '0;
		fetch_addr = '0;
		cycle_count = 0;
		lcg_state = 32'd16;
		repeat (2) @(posedge core_clk);
		#1;
		check_io_rst("during reset", io_rst, 1'b1);
		core_rst = 1'b0;

		reset_state_and_io_rst();
		load_and_fetch_words();
		fetch_while_programming();
		data_high_with_mode_off();
		back_to_back_overrun();
		zero_readback();

		$display("Test completed successfully");
		$finish;
	end

endmodule

/* pgm_loader_top.sv */
// ======================================
// Program loader top. Boot registers feed a
// write queue that drains into program memory.
// pgm_idle is high once every write has landed.
// ======================================

module pgm_loader_top #(
	parameter int PGM_ADDR_WIDTH = 10,
	parameter int QUEUE_DEPTH = 4
) (
	input  logic                      core_clk,
	input  logic                      core_rst,
	input  io_map_pkg::io_bus_t       io_bus,
	output logic [7:0]                io_rdata,
	output logic                      io_rst,
	input  logic [PGM_ADDR_WIDTH-1:0] fetch_addr,
	output pgm_pkg::pgm_word_t        fetch_data,
	output logic                      pgm_idle
);

	logic                fetch_block;
	logic                wr_req;
	logic                wr_ack;
	pgm_pkg::pgm_write_t wr_item;
	logic                slot_busy;
	logic                mem_req;
	logic                mem_ack;
	pgm_pkg::pgm_write_t mem_item;
	logic                queue_idle;

	assign pgm_idle = !slot_busy && queue_idle;

	boot_ctrl_regs u_regs (
		.core_clk    (core_clk),
		.core_rst    (core_rst),
		.io_bus      (io_bus),
		.io_rdata    (io_rdata),
		.io_rst      (io_rst),
		.fetch_block (fetch_block),
		.wr_req      (wr_req),
		.wr_ack      (wr_ack),
		.wr_item     (wr_item),
		.slot_busy   (slot_busy)
	);

	pgm_write_queue #(
		.QUEUE_DEPTH (QUEUE_DEPTH),
		.pgm_queue_t (pgm_pkg::pgm_write_t)
	) u_queue (
		.core_clk   (core_clk),
		.core_rst   (core_rst),
		.wr_req     (wr_req),
		.wr_ack     (wr_ack),
		.wr_item    (wr_item),
		.mem_req    (mem_req),
		.mem_ack    (mem_ack),
		.mem_item   (mem_item),
		.queue_idle (queue_idle)
	);

	pgm_flash #(
		.PGM_ADDR_WIDTH (PGM_ADDR_WIDTH)
	) u_flash (
		.core_clk    (core_clk),
		.core_rst    (core_rst),
		.mem_req     (mem_req),
		.mem_ack     (mem_ack),
		.mem_item    (mem_item),
		.fetch_block (fetch_block),
		.fetch_addr  (fetch_addr),
		.fetch_data  (fetch_data)
	);

endmodule

/* pgm_flash.sv */
// ======================================
// Application program memory. Written once
// per four-phase handshake, read through a
// one-cycle instruction fetch port.
// ======================================

module pgm_flash #(
	parameter int PGM_ADDR_WIDTH = 10
) (
	input  logic                      core_clk,
	input  logic                      core_rst,
	input  logic                      mem_req,
	output logic                      mem_ack,
	input  pgm_pkg::pgm_write_t       mem_item,
	input  logic                      fetch_block,
	input  logic [PGM_ADDR_WIDTH-1:0] fetch_addr,
	output pgm_pkg::pgm_word_t        fetch_data
);

	pgm_pkg::pgm_word_t words [2**PGM_ADDR_WIDTH];
	pgm_pkg::pgm_word_t rd_word;
	logic               wr_en;

	// Write on the edge where ack rises
	assign wr_en = mem_req && !mem_ack;

	always_ff @(posedge core_clk)
	begin
		if (wr_en)
			words[mem_item.addr[PGM_ADDR_WIDTH-1:0]] <= mem_item.data;  // Low bits only
		rd_word <= words[fetch_addr];
	end

	// Four-phase receiver
	always_ff @(posedge core_clk)
	begin
		if (core_rst)
			mem_ack <= 1'b0;
		else if (wr_en)
			mem_ack <= 1'b1;
		else if (!mem_req)
			mem_ack <= 1'b0;
	end

	// Core sees no code while the loader owns the memory
	assign fetch_data = fetch_block ? '0 : rd_word;

	// Req still up when the new ack is seen
	a_ack_needs_req: assert property (@(posedge core_clk) disable iff (core_rst)
		$rose(mem_ack) |-> mem_req);

endmodule

/* pgm_write_queue.sv */
// ======================================
// Circular FIFO of program-word writes.
// Four-phase receiver towards the register
// block, four-phase sender towards memory.
// ======================================

module pgm_write_queue #(
	parameter int  QUEUE_DEPTH = 4,
	parameter type pgm_queue_t = pgm_pkg::pgm_write_t
) (
	input  logic       core_clk,
	input  logic       core_rst,
	input  logic       wr_req,
	output logic       wr_ack,
	input  pgm_queue_t wr_item,
	output logic       mem_req,
	input  logic       mem_ack,
	output pgm_queue_t mem_item,
	output logic       queue_idle
);

	localparam int PTR_WIDTH = (QUEUE_DEPTH > 1) ? $clog2(QUEUE_DEPTH) : 1;

	pgm_queue_t           entries [QUEUE_DEPTH];
	logic [PTR_WIDTH-1:0] wr_ptr;
	logic [PTR_WIDTH-1:0] rd_ptr;
	logic [PTR_WIDTH:0]   count;
	logic                 full;
	logic                 empty;
	logic                 push;
	logic                 pop;

	assign full = (count == QUEUE_DEPTH);
	assign empty = (count == '0);

	// New request seen while ack is still low
	assign push = wr_req && !wr_ack && !full;
	// Ack seen while req still up, so once per handshake
	assign pop = mem_req && mem_ack;

	assign mem_item = entries[rd_ptr];
	assign queue_idle = empty && !wr_req && !mem_req;

	always_ff @(posedge core_clk)
	begin
		if (push)
			entries[wr_ptr] <= wr_item;
	end

	always_ff @(posedge core_clk)
	begin
		if (core_rst)
		begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
			wr_ack <= 1'b0;
			mem_req <= 1'b0;
		end
		else
		begin
			if (push)
			begin
				wr_ptr <= wr_ptr + 1'b1;  // Wraps, depth is a power of two
				wr_ack <= 1'b1;
			end
			else if (!wr_req)
				wr_ack <= 1'b0;

			if (pop)
			begin
				rd_ptr <= rd_ptr + 1'b1;
				mem_req <= 1'b0;
			end
			else if (!mem_req && !mem_ack && !empty)
				mem_req <= 1'b1;  // Link idle and data waiting

			count <= count + push - pop;
		end
	end

	// Occupancy never passes the depth, so no push landed on a full FIFO
	a_no_push_full: assert property (@(posedge core_clk) disable iff (core_rst)
		count <= QUEUE_DEPTH);

endmodule

/* boot_ctrl_regs.sv */
// ======================================
// Boot register window on the IO bus. Collects
// address and data bytes, and a data-high write
// in programming mode hands one word to the
// write queue over a four-phase req/ack link.
// ======================================

module boot_ctrl_regs (
	input  logic                 core_clk,
	input  logic                 core_rst,
	input  io_map_pkg::io_bus_t  io_bus,
	output logic [7:0]           io_rdata,
	output logic                 io_rst,
	output logic                 fetch_block,
	output logic                 wr_req,
	input  logic                 wr_ack,
	output pgm_pkg::pgm_write_t  wr_item,
	output logic                 slot_busy
);

	typedef enum logic [1:0] {
		slot_empty,
		slot_loaded,
		slot_req,
		slot_drain
	} slot_state_t;

	slot_state_t slot_state;
	logic [7:0]  f_cnt_l;
	logic [7:0]  f_cnt_h;
	logic [7:0]  f_data_l;
	logic [7:0]  boot_stat;
	logic        win_hit;
	logic [2:0]  win_off;
	logic        win_wr;
	logic        data_h_wr;
	logic        pgm_accept;

	assign win_hit = (io_bus.addr & io_map_pkg::boot_reg_base) == io_map_pkg::boot_reg_base;
	assign win_off = io_bus.addr[2:0];
	assign win_wr = io_bus.wr && win_hit;

	// Data-high only counts in programming mode
	assign data_h_wr = win_wr && (win_off == io_map_pkg::f_data_h_off) && fetch_block;
	assign pgm_accept = data_h_wr && !slot_busy;

	assign fetch_block = boot_stat[io_map_pkg::stat_pgm_wr_en_bit];
	assign io_rst = core_rst | boot_stat[io_map_pkg::stat_io_rst_bit];
	assign slot_busy = (slot_state != slot_empty);
	assign wr_req = (slot_state == slot_req);

	// Counter and status registers
	always_ff @(posedge core_clk)
	begin
		if (core_rst)
		begin
			f_cnt_l <= '0;
			f_cnt_h <= '0;
			boot_stat <= '0;
		end
		else if (win_wr)
		begin
			case (win_off)
				io_map_pkg::f_cnt_l_off: f_cnt_l <= io_bus.wdata;
				io_map_pkg::f_cnt_h_off: f_cnt_h <= io_bus.wdata;
				io_map_pkg::f_data_h_off:
				begin
					if (pgm_accept)
						{f_cnt_h, f_cnt_l} <= {f_cnt_h, f_cnt_l} + 16'd1;
					else if (data_h_wr)
						boot_stat[io_map_pkg::stat_overrun_bit] <= 1'b1;  // Slot still busy
				end
				io_map_pkg::boot_stat_off:
					boot_stat <= io_bus.wdata & ~(8'd1 << io_map_pkg::stat_overrun_bit);
				default: ;
			endcase
		end
	end

	always_ff @(posedge core_clk)
	begin
		if (win_wr && (win_off == io_map_pkg::f_data_l_off))
			f_data_l <= io_bus.wdata;
	end

	// Slot payload, high byte taken straight from the bus
	always_ff @(posedge core_clk)
	begin
		if (pgm_accept)
		begin
			wr_item.addr <= {f_cnt_h, f_cnt_l};
			wr_item.data <= {io_bus.wdata, f_data_l};
		end
	end

	// Four-phase sender for the one-entry slot
	always_ff @(posedge core_clk)
	begin
		if (core_rst)
			slot_state <= slot_empty;
		else
		begin
			case (slot_state)
				slot_empty: if (pgm_accept) slot_state <= slot_loaded;
				slot_loaded: slot_state <= slot_req;
				slot_req: if (wr_ack) slot_state <= slot_drain;  // Drop req
				slot_drain: if (!wr_ack) slot_state <= slot_empty;
				default: slot_state <= slot_empty;
			endcase
		end
	end

	// Readback of counter and status only
	always_comb
	begin
		io_rdata = 8'h00;
		if (io_bus.rd && win_hit)
		begin
			case (win_off)
				io_map_pkg::f_cnt_l_off: io_rdata = f_cnt_l;
				io_map_pkg::f_cnt_h_off: io_rdata = f_cnt_h;
				io_map_pkg::boot_stat_off: io_rdata = boot_stat;
				default: io_rdata = 8'h00;
			endcase
		end
	end

	// Item held steady for the whole request phase
	a_item_stable: assert property (@(posedge core_clk) disable iff (core_rst)
		wr_req |=> (!wr_req || $stable(wr_item)));

endmodule

/* pgm_pkg.sv */
// ======================================
// Program memory word, address and write
// request types shared by the loader blocks.
// ======================================

package pgm_pkg;

	// One instruction word
	typedef logic [15:0] pgm_word_t;

	// Full word address as held in the counter registers.
	// The memory itself only decodes the low bits.
	typedef logic [15:0] pgm_full_addr_t;

	// Pending write into program memory
	typedef struct packed {
		pgm_full_addr_t addr;
		pgm_word_t      data;
	} pgm_write_t;

endpackage

/* io_map_pkg.sv */
// ======================================
// IO bus request type and the boot register
// window map. Address offsets and status bit
// positions are used by the register block.
// ======================================

package io_map_pkg;

	// IO bus request as driven by the core side
	typedef struct packed {
		logic [7:0] addr;
		logic [7:0] wdata;
		logic       wr;
		logic       rd;
	} io_bus_t;

	// Window covers every address with the top five bits set
	localparam logic [7:0] boot_reg_base = 8'hF8;

	// Offsets inside the window
	localparam logic [2:0] f_cnt_l_off   = 3'd3;  // Word address low
	localparam logic [2:0] f_cnt_h_off   = 3'd4;  // Word address high
	localparam logic [2:0] f_data_l_off  = 3'd5;
	localparam logic [2:0] f_data_h_off  = 3'd6;  // Commits the word
	localparam logic [2:0] boot_stat_off = 3'd7;

	// Boot status bits
	localparam int stat_pgm_wr_en_bit = 3;  // Programming mode
	localparam int stat_io_rst_bit    = 4;
	localparam int stat_overrun_bit   = 5;  // Sticky, cleared by a status write

endpackage
